// File: testbench/merge_testdata.txt
# Columns hex except N: C addr data, D rounds, L lane value, N idle_cycles
# Columns continued: E tag lane0 lane1 lane2 lane3, X expects done_out high
# basic_merge reset defaults, all four lanes, tag 0
X
D 1
E 0000 11111111 22222222 33333333 44444444
L 2 33333333
L 0 11111111
L 3 44444444
L 1 22222222
X
# seq_tags start tag 100 over three rounds
C 1 64
D 3
E 0064 a0000000 a0000001 a0000002 a0000003
E 0065 b0000000 b0000001 b0000002 b0000003
E 0066 c0000000 c0000001 c0000002 c0000003
L 0 a0000000
L 1 a0000001
L 2 a0000002
L 3 a0000003
L 3 b0000003
L 1 b0000001
L 0 b0000000
L 2 b0000002
L 1 c0000001
L 0 c0000000
L 2 c0000002
L 3 c0000003
X
# lane_mask only lanes 0 and 2 enabled
C 0 5
D 1
E 0064 d0000000 00000000 d0000002 00000000
L 1 deadbeef
L 0 d0000000
L 3 deadbeef
L 2 d0000002
X
# lane_repeat later packet on a full slot wins
C 0 f
D 1
E 0064 01010101 0b0b0b0b 03030303 04040404
L 1 02020202
L 0 01010101
L 1 0b0b0b0b
L 2 03030303
L 3 04040404
X
# idle_and_busy packets while idle and a mask write during the run
L 0 99999999
L 2 88888888
N 3
D 1
C 0 1
E 0064 50000000 50000001 50000002 50000003
L 1 50000001
L 3 50000003
L 2 50000002
L 0 50000000
X

// File: files.f
hdl/merge_data_pkg.sv
hdl/merge_input_stage.sv
hdl/merge_config_regs.sv
hdl/merge_lane_collector.sv
hdl/engine_merge_data.sv
testbench/tb_engine_merge_data.sv

// File: Makefile
TOP := tb_engine_merge_data
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wall -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing -Wno-fatal -f files.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: testbench/tb_engine_merge_data.sv
`timescale 1ns/10ps

module tb_engine_merge_data;

    import merge_data_pkg::*;

    localparam int num_lanes = 4;
    // Merged word without the valid bit with the tag above lane 3 down to lane 0
    localparam int out_w = seq_w + num_lanes * lane_data_w;

    logic             ap_clk;
    logic             areset_merge_data_engine;
    descriptor_t      descriptor_in;
    memory_response_t response_memory_in;
    lane_packet_t     response_engine_in [num_lanes-1:0];
    logic [out_w:0]   request_engine_out;
    logic             done_out;

    // Expected merged packets in arrival order with their test names
    logic [out_w-1:0] exp_q  [$];
    logic [8*32-1:0]  name_q [$];
    logic [8*32-1:0]  cur_test;
    int               line_count;
    int               err_value;
    int               err_missing;
    int               err_extra;
    int               err_other;

    engine_merge_data #(
        .num_lanes(num_lanes)
    ) u_engine_merge_data (
        .ap_clk                  (ap_clk),
        .areset_merge_data_engine(areset_merge_data_engine),
        .descriptor_in           (descriptor_in),
        .response_memory_in      (response_memory_in),
        .response_engine_in      (response_engine_in),
        .request_engine_out      (request_engine_out),
        .done_out                (done_out)
    );

    // ----------------------------------------------------------------------
    // 10 ns clock
    // ----------------------------------------------------------------------
    initial ap_clk = 1'b0;
    always #5 ap_clk = ~ap_clk;

    // ----------------------------------------------------------------------
    // Stimulus tasks entered and left on a falling edge
    // ----------------------------------------------------------------------

    // One configuration word strobe
    task automatic write_config(input logic [31:0] addr, input logic [31:0] data);
        response_memory_in.valid    = 1'b1;
        response_memory_in.cfg_addr = addr[cfg_addr_w-1:0];
        response_memory_in.cfg_data = data;
        @(negedge ap_clk);
        response_memory_in.valid = 1'b0;
    endtask

    // Descriptor strobe and the done_out level two cycles later
    task automatic start_run(input logic [31:0] rounds);
        logic exp_done;
        exp_done                 = (rounds[round_w-1:0] == '0);
        descriptor_in.valid      = 1'b1;
        descriptor_in.num_rounds = rounds[round_w-1:0];
        @(negedge ap_clk);
        descriptor_in.valid = 1'b0;
        @(negedge ap_clk);
        if (done_out !== exp_done) begin
            err_value++;
            $display("CHECK FAILED %0s done_out after descriptor expected %b actual %b",
                     cur_test, exp_done, done_out);
        end
    endtask

    // One lane packet and a random gap of 0 to 2 cycles
    task automatic send_lane(input logic [31:0] lane, input logic [31:0] value);
        int unsigned gap;
        response_engine_in[lane[1:0]].valid = 1'b1;
        response_engine_in[lane[1:0]].data  = value;
        @(negedge ap_clk);
        response_engine_in[lane[1:0]].valid = 1'b0;
        gap = $urandom % 3;
        repeat (gap) @(negedge ap_clk);
    endtask

    // Waits for all predicted packets and then expects done_out high
    task automatic check_done();
        while (exp_q.size() != 0) begin
            @(negedge ap_clk);
        end
        @(negedge ap_clk);
        @(negedge ap_clk);
        if (done_out !== 1'b1) begin
            err_value++;
            $display("CHECK FAILED %0s done_out expected 1 actual %b", cur_test, done_out);
        end
    endtask

    // Flags a data file command that lacks fields
    task automatic check_fields(input int got, input int want, input logic [7:0] command);
        if (got != want) begin
            err_other++;
            $display("Data file command %c has %0d fields instead of %0d",
                     command, got, want);
        end
    endtask

    // ----------------------------------------------------------------------
    // Output monitor
    // ----------------------------------------------------------------------
    always @(negedge ap_clk) begin
        if (!areset_merge_data_engine && request_engine_out[out_w] === 1'b1) begin
            if (exp_q.size() == 0) begin
                err_extra++;
                $display("Merged packet with tag %h arrived with none expected",
                         request_engine_out[out_w-1 -: seq_w]);
            end else begin
                if (request_engine_out[out_w-1:0] !== exp_q[0]) begin
                    err_value++;
                    $display("CHECK FAILED %0s merged packet expected %h actual %h",
                             name_q[0], exp_q[0], request_engine_out[out_w-1:0]);
                end
                exp_q.delete(0);
                name_q.delete(0);
            end
        end
    end

    // ----------------------------------------------------------------------
    // Data file driven sequence
    // ----------------------------------------------------------------------
    initial begin : stimulus
        logic [7:0]       cmd;
        logic [8*32-1:0]  word;
        logic [8*128-1:0] text;
        logic [31:0]      f0;
        logic [31:0]      f1;
        logic [31:0]      f2;
        logic [31:0]      f3;
        logic [31:0]      f4;
        int               fd;
        int               code;

        void'($urandom(32'h1cd));
        areset_merge_data_engine = 1'b1;
        descriptor_in            = '0;
        response_memory_in       = '0;
        for (int i = 0; i < num_lanes; i++) begin
            response_engine_in[i] = '0;
        end
        cur_test = "reset";

        // Line count sizes the watchdog
        fd = $fopen("testbench/merge_testdata.txt", "r");
        if (fd == 0) begin
            err_other++;
            $display("Cannot open testbench/merge_testdata.txt");
        end else begin
            while ($fgets(text, fd) != 0) begin
                line_count++;
            end
            $fclose(fd);
            fd = $fopen("testbench/merge_testdata.txt", "r");
        end

        repeat (3) @(negedge ap_clk);
        areset_merge_data_engine = 1'b0;

        while (fd != 0 && $fscanf(fd, "%s", cmd) == 1) begin
            case (cmd)
                "#": begin
                    // First word of a comment names the test
                    code     = $fscanf(fd, "%s", word);
                    check_fields(code, 1, cmd);
                    cur_test = word;
                    code     = $fgets(text, fd);
                end
                "C": begin
                    code = $fscanf(fd, "%h %h", f0, f1);
                    check_fields(code, 2, cmd);
                    write_config(f0, f1);
                end
                "D": begin
                    code = $fscanf(fd, "%h", f0);
                    check_fields(code, 1, cmd);
                    start_run(f0);
                end
                "L": begin
                    code = $fscanf(fd, "%h %h", f0, f1);
                    check_fields(code, 2, cmd);
                    send_lane(f0, f1);
                end
                "N": begin
                    code = $fscanf(fd, "%d", f0);
                    check_fields(code, 1, cmd);
                    repeat (f0) @(negedge ap_clk);
                end
                "E": begin
                    code = $fscanf(fd, "%h %h %h %h %h", f0, f1, f2, f3, f4);
                    check_fields(code, 5, cmd);
                    exp_q.push_back({f0[seq_w-1:0], f4, f3, f2, f1});
                    name_q.push_back(cur_test);
                end
                "X": check_done();
                default: begin
                    err_other++;
                    $display("Unknown command %c in the data file", cmd);
                end
            endcase
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        // Room for late or stray packets
        repeat (20) @(negedge ap_clk);
        err_missing = exp_q.size();
        while (name_q.size() != 0) begin
            $display("Merged packet for %0s never arrived", name_q[0]);
            name_q.delete(0);
        end

        $display("Errors: wrong values %0d, missing %0d, extra %0d, other %0d",
                 err_value, err_missing, err_extra, err_other);
        if (err_value + err_missing + err_extra + err_other == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Watchdog allows 40 cycles per data file line
    initial begin : watchdog
        @(negedge areset_merge_data_engine);
        repeat (line_count * 40) @(posedge ap_clk);
        $display("Timeout after %0d cycles, the run did not finish", line_count * 40);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule : tb_engine_merge_data

// File: hdl/engine_merge_data.sv
`timescale 1ns/10ps

module engine_merge_data #(
    parameter int num_lanes = 4
) (
    input  logic                           ap_clk,
    input  logic                           areset_merge_data_engine,
    input  merge_data_pkg::descriptor_t      descriptor_in,
    input  merge_data_pkg::memory_response_t response_memory_in,
    input  merge_data_pkg::lane_packet_t     response_engine_in [num_lanes-1:0],
    output logic [merge_data_pkg::seq_w+num_lanes*merge_data_pkg::lane_data_w:0]
                                           request_engine_out,
    output logic                           done_out
);

    import merge_data_pkg::*;

    // ----------------------------------------------------------------------
    // Stage interconnect
    // ----------------------------------------------------------------------
    descriptor_t          descriptor_reg;
    memory_response_t     memory_response_reg;
    lane_packet_t         lane_packet_reg [num_lanes-1:0];
    logic                 engine_idle;
    logic [num_lanes-1:0] lane_mask;
    seq_t                 seq_start;

    // Registered input edge
    merge_input_stage #(
        .num_lanes(num_lanes)
    ) u_merge_input_stage (
        .ap_clk                  (ap_clk),
        .areset_merge_data_engine(areset_merge_data_engine),
        .descriptor_in           (descriptor_in),
        .response_memory_in      (response_memory_in),
        .response_engine_in      (response_engine_in),
        .descriptor_reg          (descriptor_reg),
        .memory_response_reg     (memory_response_reg),
        .lane_packet_reg         (lane_packet_reg)
    );

    // Lane mask and start tag from memory responses
    merge_config_regs #(
        .num_lanes(num_lanes)
    ) u_merge_config_regs (
        .ap_clk                  (ap_clk),
        .areset_merge_data_engine(areset_merge_data_engine),
        .memory_response_reg     (memory_response_reg),
        .engine_idle             (engine_idle),
        .lane_mask               (lane_mask),
        .seq_start               (seq_start)
    );

    // Merge generator with output register and done
    merge_lane_collector #(
        .num_lanes(num_lanes)
    ) u_merge_lane_collector (
        .ap_clk                  (ap_clk),
        .areset_merge_data_engine(areset_merge_data_engine),
        .descriptor_reg          (descriptor_reg),
        .lane_packet_reg         (lane_packet_reg),
        .lane_mask               (lane_mask),
        .seq_start               (seq_start),
        .engine_idle             (engine_idle),
        .request_engine_out      (request_engine_out),
        .done_out                (done_out)
    );

endmodule : engine_merge_data

// File: hdl/merge_lane_collector.sv
`timescale 1ns/10ps

module merge_lane_collector #(
    parameter int num_lanes = 4
) (
    input  logic                         ap_clk,
    input  logic                         areset_merge_data_engine,
    input  merge_data_pkg::descriptor_t    descriptor_reg,
    input  merge_data_pkg::lane_packet_t   lane_packet_reg [num_lanes-1:0],
    input  logic [num_lanes-1:0]         lane_mask,
    input  merge_data_pkg::seq_t           seq_start,
    output logic                         engine_idle,
    output logic [merge_data_pkg::seq_w+num_lanes*merge_data_pkg::lane_data_w:0]
                                         request_engine_out,
    output logic                         done_out
);

    import merge_data_pkg::*;

    // Merged request, valid on top, lane 0 in the low word
    typedef struct packed {
        logic                       valid;
        seq_t                       seq;
        lane_data_t [num_lanes-1:0] data;
    } merged_packet_t;

    collector_state_t     state_q;
    collector_state_t     state_nxt;
    round_t               rounds_left_q;
    seq_t                 seq_cur_q;
    logic [num_lanes-1:0] slot_full_q;
    logic [num_lanes-1:0] slot_full_nxt;
    logic [num_lanes-1:0] lane_accept;
    lane_data_t           slot_data_q   [num_lanes-1:0];
    lane_data_t           slot_data_nxt [num_lanes-1:0];
    logic                 run_start;
    logic                 run_active;
    logic                 round_done;
    merged_packet_t       req_q;

    // ----------------------------------------------------------------------
    // Round tracking
    // ----------------------------------------------------------------------

    // Zero round descriptor leaves the collector idle
    assign run_start = (state_q == idle) & descriptor_reg.valid
                     & (descriptor_reg.num_rounds != '0);

    // Emit cycle still takes packets if more rounds remain
    assign run_active = (state_q == collect)
                      | ((state_q == emit) & (rounds_left_q != '0));

    // Slot update, a repeat packet on a full slot overwrites it
    always_comb begin
        for (int i = 0; i < num_lanes; i++) begin
            lane_accept[i]   = run_active & lane_mask[i] & lane_packet_reg[i].valid;
            slot_full_nxt[i] = slot_full_q[i] | lane_accept[i];
            slot_data_nxt[i] = lane_accept[i] ? lane_packet_reg[i].data : slot_data_q[i];
        end
    end

    // Round complete once every enabled slot holds data
    assign round_done = run_active & (&(slot_full_nxt | ~lane_mask));

    // ----------------------------------------------------------------------
    // Round FSM
    // ----------------------------------------------------------------------
    always_comb begin
        state_nxt = state_q;
        case (state_q)
            idle: begin
                if (run_start) begin
                    state_nxt = collect;
                end
            end
            collect: begin
                if (round_done) begin
                    state_nxt = emit;
                end
            end
            emit: begin
                // Back to back rounds stay here
                if (round_done) begin
                    state_nxt = emit;
                end else if (rounds_left_q == '0) begin
                    state_nxt = idle;
                end else begin
                    state_nxt = collect;
                end
            end
            default: state_nxt = idle;
        endcase
    end

    always_ff @(posedge ap_clk) begin
        if (areset_merge_data_engine) begin
            state_q       <= idle;
            rounds_left_q <= '0;
            slot_full_q   <= '0;
            done_out      <= 1'b1;
        end else begin
            state_q  <= state_nxt;
            // High one cycle after the last merged packet
            done_out <= (state_nxt == idle);
            if (run_start) begin
                rounds_left_q <= descriptor_reg.num_rounds;
            end else if (round_done) begin
                rounds_left_q <= rounds_left_q - 1'b1;
            end
            // Fresh round starts empty
            slot_full_q <= round_done ? '0 : slot_full_nxt;
        end
    end

    // ----------------------------------------------------------------------
    // Lane slots, tag and merged output
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        slot_data_q <= slot_data_nxt;
        // Tag wraps at seq_w bits
        if (run_start) begin
            seq_cur_q <= seq_start;
        end else if (round_done) begin
            seq_cur_q <= seq_cur_q + 1'b1;
        end
    end

    always_ff @(posedge ap_clk) begin
        req_q.seq <= seq_cur_q;
        for (int i = 0; i < num_lanes; i++) begin
            // Disabled lanes read as zero
            req_q.data[i] <= lane_mask[i] ? slot_data_nxt[i] : '0;
        end
        if (areset_merge_data_engine) begin
            req_q.valid <= 1'b0;
        end else begin
            req_q.valid <= round_done;
        end
    end

    assign engine_idle        = (state_q == idle);
    assign request_engine_out = req_q;

endmodule : merge_lane_collector

// File: hdl/merge_config_regs.sv
`timescale 1ns/10ps

module merge_config_regs #(
    parameter int num_lanes = 4
) (
    input  logic                           ap_clk,
    input  logic                           areset_merge_data_engine,
    input  merge_data_pkg::memory_response_t memory_response_reg,
    input  logic                           engine_idle,
    output logic [num_lanes-1:0]           lane_mask,
    output merge_data_pkg::seq_t             seq_start
);

    import merge_data_pkg::*;

    logic wr_en;
    logic wr_lane_mask;
    logic wr_seq_start;

    // ----------------------------------------------------------------------
    // Address decode
    // ----------------------------------------------------------------------

    // Config words only land between runs
    assign wr_en = memory_response_reg.valid & engine_idle;

    always_comb begin
        wr_lane_mask = 1'b0;
        wr_seq_start = 1'b0;
        case (memory_response_reg.cfg_addr)
            cfg_addr_lane_mask: wr_lane_mask = wr_en;
            cfg_addr_seq_start: wr_seq_start = wr_en;
            // Unknown index, silently dropped
            default: begin
            end
        endcase
    end

    // ----------------------------------------------------------------------
    // Configuration registers
    // ----------------------------------------------------------------------

    // All lanes enabled and tag 0 out of reset
    always_ff @(posedge ap_clk) begin
        if (areset_merge_data_engine) begin
            lane_mask <= '1;
            seq_start <= '0;
        end else begin
            if (wr_lane_mask) begin
                // Low bits only, one per lane
                lane_mask <= memory_response_reg.cfg_data[num_lanes-1:0];
            end
            if (wr_seq_start) begin
                seq_start <= memory_response_reg.cfg_data[seq_w-1:0];
            end
        end
    end

endmodule : merge_config_regs

// File: hdl/merge_input_stage.sv
`timescale 1ns/10ps

module merge_input_stage #(
    parameter int num_lanes = 4
) (
    input  logic                           ap_clk,
    input  logic                           areset_merge_data_engine,
    input  merge_data_pkg::descriptor_t      descriptor_in,
    input  merge_data_pkg::memory_response_t response_memory_in,
    input  merge_data_pkg::lane_packet_t     response_engine_in [num_lanes-1:0],
    output merge_data_pkg::descriptor_t      descriptor_reg,
    output merge_data_pkg::memory_response_t memory_response_reg,
    output merge_data_pkg::lane_packet_t     lane_packet_reg [num_lanes-1:0]
);

    // ----------------------------------------------------------------------
    // Descriptor and memory response
    // ----------------------------------------------------------------------

    // Whole struct registered every cycle
    // Valid bit forced low while in reset
    always_ff @(posedge ap_clk) begin
        descriptor_reg      <= descriptor_in;
        memory_response_reg <= response_memory_in;
        if (areset_merge_data_engine) begin
            descriptor_reg.valid      <= 1'b0;
            memory_response_reg.valid <= 1'b0;
        end
    end

    // ----------------------------------------------------------------------
    // Engine response lanes
    // ----------------------------------------------------------------------

    // One register per lane, each lane strobes on its own
    always_ff @(posedge ap_clk) begin
        for (int i = 0; i < num_lanes; i++) begin
            lane_packet_reg[i] <= response_engine_in[i];
        end
        if (areset_merge_data_engine) begin
            // Drop any strobe captured during reset
            for (int i = 0; i < num_lanes; i++) begin
                lane_packet_reg[i].valid <= 1'b0;
            end
        end
    end

endmodule : merge_input_stage

// File: hdl/merge_data_pkg.sv
package merge_data_pkg;

    // ----------------------------------------------------------------------
    // Widths
    // ----------------------------------------------------------------------

    // One lane data value
    localparam int lane_data_w = 32;
    // Sequence tag carried by every merged packet
    localparam int seq_w = 16;
    // Round counter, as given by the kernel descriptor
    localparam int round_w = 16;
    // Configuration word index
    localparam int cfg_addr_w = 4;

    // ----------------------------------------------------------------------
    // Plain vector types
    // ----------------------------------------------------------------------
    typedef logic [lane_data_w-1:0] lane_data_t;
    typedef logic [seq_w-1:0]       seq_t;
    typedef logic [round_w-1:0]     round_t;
    typedef logic [cfg_addr_w-1:0]  cfg_addr_t;

    // Configuration word map, other indices are dropped
    localparam cfg_addr_t cfg_addr_lane_mask = cfg_addr_t'(0);
    localparam cfg_addr_t cfg_addr_seq_start = cfg_addr_t'(1);

    // ----------------------------------------------------------------------
    // Packets
    // ----------------------------------------------------------------------

    // Kernel descriptor, starts a run of num_rounds merges
    typedef struct packed {
        logic   valid;
        round_t num_rounds;
    } descriptor_t;

    // Memory response, writes one configuration word
    typedef struct packed {
        logic        valid;
        cfg_addr_t   cfg_addr;
        logic [31:0] cfg_data;
    } memory_response_t;

    // Data packet from one engine response lane
    typedef struct packed {
        logic       valid;
        lane_data_t data;
    } lane_packet_t;

    // Round FSM of the lane collector
    typedef enum logic [1:0] {
        idle,
        collect,
        emit
    } collector_state_t;

endpackage : merge_data_pkg
